//--- csrUnit.f
+incdir+include
source/csrPkg.sv
source/csrWriteValue.sv
source/csrTrapLogic.sv
source/csrMachineRegs.sv
source/csrCounters.sv
source/csrUnit.sv
tests/csrUnitTb.sv

//--- tests/csrUnitTb.sv
//////////////////////////////
// Random testbench for the CSR unit
// Reference model of every machine CSR, stops at the first mismatch
//////////////////////////////

`include "csrUnit_cfg.svh"

module csrUnitTb;
  timeunit 1ns;
  timeprecision 1ps;

  logic clk = 1'b0;
  logic rstN, stallW, flushW, illegalAccess;
  csrPkg::csrReqT  csrReq;
  csrPkg::trapReqT trapReq, t;
  csrPkg::irqT     irq;
  csrPkg::privT    privilegeW;
  csrPkg::statusT  status, refStatus, oldStatus;
  csrPkg::xlenT    csrReadValW, trapVector, epc, mie, mip;
  csrPkg::xlenT    refScratch, refTvec, refIe, refEpc, refCause, refTval;  // Model copies
  csrPkg::xlenT    sawVector, sawEpc, src, old, v0;
  csrPkg::csrAdrT  adr;
  csrPkg::csrOpT   op;
  logic            refSip, sawIllegal, useImm;
  integer          seed = 71796;
  integer          i, n;

  always #10 clk = ~clk;  // 20 ns period

  csrUnit dut_i (.clk, .rstN, .stallW, .flushW, .csrReq, .trapReq, .irq, .privilegeW,
    .csrReadValW, .illegalAccess, .trapVector, .epc, .status, .mie, .mip);

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic abortRun();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped after first error");
  endtask

  task automatic checkXlen(input string name, input csrPkg::xlenT got, input csrPkg::xlenT exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      abortRun();
    end
  endtask

  task automatic checkStatus(input string name, input csrPkg::statusT got,
      input csrPkg::statusT exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      abortRun();
    end
  endtask

  task automatic checkFlag(input string name, input bit got, input bit exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
      abortRun();
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic csrPkg::xlenT rmw(input csrPkg::csrOpT o, input csrPkg::xlenT cur,
      input csrPkg::xlenT s);
    case (o)
      csrPkg::opRw: return s;
      csrPkg::opRs: return cur | s;
      csrPkg::opRc: return cur & ~s;
      default:      return cur;
    endcase
  endfunction

  function automatic csrPkg::xlenT tvalForCause(input csrPkg::trapReqT tr);
    if (tr.interrupt) return '0;
    case (tr.cause)
      1, 3, 12:              return tr.pc;
      2:                     return tr.instrOrig;  // Illegal instruction bits
      0, 4, 5, 6, 7, 13, 15: return tr.faultAdr;
      default:               return '0;            // ecall and reserved codes
    endcase
  endfunction

  function automatic csrPkg::xlenT vectorFor(input csrPkg::xlenT tvec, input csrPkg::trapReqT tr);
    csrPkg::xlenT v;
    v = tvec & ~32'h3;
    if (tr.interrupt && tvec[1:0] == 2'b01) v[5:2] = tr.cause;  // Vectored interrupt slot
    return v;
  endfunction

  function automatic csrPkg::xlenT mipView();
    return {20'b0, irq.mExt, 3'b0, irq.mTimer, 3'b0, irq.mSw | refSip, 3'b0};
  endfunction

  function automatic csrPkg::xlenT csrValue(input csrPkg::csrAdrT a);
    case (a)
      `CSR_ADR_MSTATUS:  return {19'b0, refStatus.mpp, 3'b0, refStatus.mpie, 3'b0,
                                 refStatus.mie, 3'b0};
      `CSR_ADR_MTVEC:    return refTvec;
      `CSR_ADR_MEPC:     return refEpc;
      `CSR_ADR_MCAUSE:   return refCause;
      `CSR_ADR_MTVAL:    return refTval;
      `CSR_ADR_MSCRATCH: return refScratch;
      `CSR_ADR_MIE:      return refIe;
      `CSR_ADR_MIP:      return mipView();
      default:           return '0;
    endcase
  endfunction

  task automatic storeCsr(input csrPkg::csrAdrT a, input csrPkg::xlenT v);
    case (a)
      `CSR_ADR_MSTATUS: begin
        refStatus.mie  = v[3];
        refStatus.mpie = v[7];
        refStatus.mpp  = (v[12:11] == 2'b11) ? csrPkg::mMode : csrPkg::uMode;  // WARL
      end
      `CSR_ADR_MTVEC:    refTvec = {v[31:2], 1'b0, v[0]};  // Direct or vectored only
      `CSR_ADR_MSCRATCH: refScratch = v;
      `CSR_ADR_MIE:      refIe = v & `CSR_MIE_MASK;
      `CSR_ADR_MIP:      refSip = v[3];
      default: ;
    endcase
  endtask

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic csrPkg::csrReqT mkReq(input csrPkg::csrAdrT a, input csrPkg::csrOpT o,
      input logic rd, input logic wr, input logic imm, input csrPkg::xlenT s);
    csrPkg::csrReqT r;
    r.valid  = 1'b1;
    r.read   = rd;
    r.write  = wr;
    r.adr    = a;
    r.op     = o;
    r.useImm = imm;
    r.imm    = s[4:0];
    r.srcA   = s;
    return r;
  endfunction

  // One pipeline slot from falling edge to falling edge
  task automatic issue(input csrPkg::csrReqT req, input csrPkg::trapReqT tr,
      input logic stall, input logic flush);
    csrReq  = req;
    trapReq = tr;
    stallW  = stall;
    flushW  = flush;
    #5;
    sawIllegal = illegalAccess;  // Same-cycle outputs
    sawVector  = trapVector;
    sawEpc     = epc;
    @(posedge clk);
    @(negedge clk);
    csrReq  = '0;
    trapReq = '0;
    stallW  = 1'b0;
    flushW  = 1'b0;
  endtask

  task automatic access(input csrPkg::csrAdrT a, input csrPkg::csrOpT o, input logic rd,
      input logic wr, input logic imm, input csrPkg::xlenT s);
    issue(mkReq(a, o, rd, wr, imm, s), '0, 1'b0, 1'b0);
  endtask

  task automatic readCsr(input csrPkg::csrAdrT a);
    access(a, csrPkg::opNone, 1'b1, 1'b0, 1'b0, '0);
  endtask

  task automatic readCheck(input csrPkg::csrAdrT a, input string name);
    readCsr(a);
    checkXlen(name, csrReadValW, csrValue(a));
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    rstN       = 1'b0;
    stallW     = 1'b0;
    flushW     = 1'b0;
    csrReq     = '0;
    trapReq    = '0;
    irq        = '0;
    privilegeW = csrPkg::mMode;
    refScratch = '0;
    refTvec    = `CSR_MTVEC_RESET;
    refIe      = '0;
    refEpc     = '0;
    refCause   = '0;
    refTval    = '0;
    refSip     = 1'b0;
    refStatus.mie  = 1'b0;
    refStatus.mpie = 1'b0;
    refStatus.mpp  = csrPkg::mMode;
    repeat (8) @(negedge clk);
    rstN = 1'b1;
    checkXlen("csrReadValW", csrReadValW, '0);
    checkStatus("status", status, refStatus);
    readCheck(`CSR_ADR_MTVEC, "mtvec");

    // Read-modify-write, old value comes back first
    for (i = 0; i < 40; i = i + 1) begin
      n      = $unsigned($random(seed)) % 3;
      adr    = (n == 0) ? `CSR_ADR_MSCRATCH : (n == 1) ? `CSR_ADR_MTVEC : `CSR_ADR_MIE;
      n      = 1 + $unsigned($random(seed)) % 3;
      op     = csrPkg::csrOpT'(n[1:0]);
      useImm = $random(seed);
      src    = $random(seed);
      if (useImm) src = src & 32'h1F;  // uimm is zero extended
      old = csrValue(adr);
      access(adr, op, 1'b1, 1'b1, useImm, src);
      checkXlen("csrReadValW", csrReadValW, old);
      storeCsr(adr, rmw(op, old, src));
      checkXlen("mie", mie, refIe);
      readCheck(adr, "csrReadValW");
    end

    // Illegal accesses
    access(12'h7C0, csrPkg::opNone, 1'b1, 1'b0, 1'b0, '0);
    checkFlag("illegalAccess", sawIllegal, 1'b1);
    privilegeW = csrPkg::uMode;
    access(`CSR_ADR_MSCRATCH, csrPkg::opRw, 1'b1, 1'b1, 1'b0, $random(seed));
    checkFlag("illegalAccess", sawIllegal, 1'b1);
    privilegeW = csrPkg::mMode;
    readCheck(`CSR_ADR_MSCRATCH, "mscratch");  // User write dropped
    access(`CSR_ADR_MHARTID, csrPkg::opRw, 1'b0, 1'b1, 1'b0, 32'h5);
    checkFlag("illegalAccess", sawIllegal, 1'b1);
    readCsr(`CSR_ADR_MHARTID);
    checkFlag("illegalAccess", sawIllegal, 1'b0);
    checkXlen("mhartid", csrReadValW, `CSR_HART_ID);

    // Trap entry, then mret
    for (i = 0; i < 24; i = i + 1) begin
      src = $random(seed);
      access(`CSR_ADR_MSTATUS, csrPkg::opRw, 1'b0, 1'b1, 1'b0, src);
      storeCsr(`CSR_ADR_MSTATUS, src);
      src = $random(seed);
      access(`CSR_ADR_MTVEC, csrPkg::opRw, 1'b0, 1'b1, 1'b0, src);
      storeCsr(`CSR_ADR_MTVEC, src);
      t           = '0;
      t.trap      = 1'b1;
      t.interrupt = $random(seed);
      t.cause     = $random(seed);
      t.pc        = $random(seed);
      t.faultAdr  = $random(seed);
      t.instrOrig = $random(seed);
      privilegeW  = ($random(seed) & 1) ? csrPkg::mMode : csrPkg::uMode;
      oldStatus   = refStatus;
      issue('0, t, 1'b0, 1'b0);
      checkXlen("trapVector", sawVector, vectorFor(refTvec, t));
      refStatus.mpie = oldStatus.mie;
      refStatus.mie  = 1'b0;
      refStatus.mpp  = privilegeW;
      refEpc         = t.pc & ~32'h3;
      refCause       = {t.interrupt, 27'b0, t.cause};
      refTval        = tvalForCause(t);
      checkStatus("status", status, refStatus);
      privilegeW = csrPkg::mMode;
      readCheck(`CSR_ADR_MEPC, "mepc");
      readCheck(`CSR_ADR_MCAUSE, "mcause");
      readCheck(`CSR_ADR_MTVAL, "mtval");
      t         = '0;
      t.mret    = 1'b1;
      oldStatus = refStatus;
      issue('0, t, 1'b0, 1'b0);
      checkXlen("epc", sawEpc, refEpc);
      refStatus.mie  = oldStatus.mpie;
      refStatus.mpie = 1'b1;
      refStatus.mpp  = csrPkg::uMode;
      checkStatus("status", status, refStatus);
    end

    // mcycle runs one per clock
    n = 2 + $unsigned($random(seed)) % 20;
    readCsr(`CSR_ADR_MCYCLE);
    v0 = csrReadValW;
    repeat (n - 1) issue('0, '0, 1'b0, 1'b0);
    readCsr(`CSR_ADR_MCYCLE);
    checkXlen("mcycle delta", csrReadValW - v0, n);
    src = $random(seed);
    access(`CSR_ADR_MCYCLE, csrPkg::opRw, 1'b0, 1'b1, 1'b0, src);
    readCsr(`CSR_ADR_MCYCLE);
    checkXlen("mcycle", csrReadValW, src);

    // minstret counts live requests only, the first read counts too
    readCsr(`CSR_ADR_MINSTRET);
    v0 = csrReadValW;
    n  = 1 + $unsigned($random(seed)) % 10;
    for (i = 0; i < n; i = i + 1) begin
      readCsr(`CSR_ADR_MSCRATCH);
      issue(mkReq(`CSR_ADR_MSCRATCH, csrPkg::opNone, 1'b1, 1'b0, 1'b0, '0), '0, 1'b1, 1'b0);
      issue(mkReq(`CSR_ADR_MSCRATCH, csrPkg::opNone, 1'b1, 1'b0, 1'b0, '0), '0, 1'b0, 1'b1);
    end
    readCsr(`CSR_ADR_MINSTRET);
    checkXlen("minstret delta", csrReadValW - v0, n + 1);

    // Inhibit bits freeze the matching counter
    access(`CSR_ADR_MCOUNTINHIBIT, csrPkg::opRw, 1'b0, 1'b1, 1'b1, 32'h1);
    readCsr(`CSR_ADR_MCYCLE);
    v0 = csrReadValW;
    repeat (5) issue('0, '0, 1'b0, 1'b0);
    readCsr(`CSR_ADR_MCYCLE);
    checkXlen("mcycle inhibited", csrReadValW, v0);
    access(`CSR_ADR_MCOUNTINHIBIT, csrPkg::opRw, 1'b0, 1'b1, 1'b1, 32'h4);
    readCsr(`CSR_ADR_MINSTRET);
    v0 = csrReadValW;
    repeat (5) readCsr(`CSR_ADR_MSCRATCH);
    readCsr(`CSR_ADR_MINSTRET);
    checkXlen("minstret inhibited", csrReadValW, v0);
    access(`CSR_ADR_MCOUNTINHIBIT, csrPkg::opRw, 1'b0, 1'b1, 1'b1, 32'h0);

    // mip, irq lines ORed with the written msip
    for (i = 0; i < 8; i = i + 1) begin
      irq = $random(seed);
      n   = 1 + $unsigned($random(seed)) % 3;
      op  = csrPkg::csrOpT'(n[1:0]);
      src = $random(seed);
      access(`CSR_ADR_MIP, op, 1'b1, 1'b1, 1'b0, src);
      old    = rmw(op, {28'b0, refSip, 3'b0}, src);  // Only msip is writable
      refSip = old[3];
      checkXlen("mip", mip, mipView());
      readCheck(`CSR_ADR_MIP, "mip read value");
    end

    // Stall holds the read value and blocks writes, flush clears it
    readCheck(`CSR_ADR_MSCRATCH, "mscratch");
    v0 = csrReadValW;
    n  = 2 + $unsigned($random(seed)) % 5;
    for (i = 0; i < n; i = i + 1) begin
      issue(mkReq(`CSR_ADR_MTVEC, csrPkg::opRw, 1'b1, 1'b1, 1'b0, $random(seed)), '0,
        1'b1, 1'b0);
      checkXlen("csrReadValW stalled", csrReadValW, v0);
    end
    readCheck(`CSR_ADR_MTVEC, "mtvec");
    issue(mkReq(`CSR_ADR_MSCRATCH, csrPkg::opNone, 1'b1, 1'b0, 1'b0, '0), '0, 1'b0, 1'b1);
    checkXlen("csrReadValW flushed", csrReadValW, '0);

    $display("TEST PASS");
    $finish;
  end

endmodule

//--- source/csrUnit.sv
//////////////////////////////
// Top of the machine-mode CSR unit
// Qualifies CSR requests against stall/flush, merges reads,
// flags illegal accesses, registers the read value for writeback
//////////////////////////////

module csrUnit (
  input  logic             clk,
  input  logic             rstN,
  input  logic             stallW,
  input  logic             flushW,
  input  csrPkg::csrReqT   csrReq,
  input  csrPkg::trapReqT  trapReq,
  input  csrPkg::irqT      irq,
  input  csrPkg::privT     privilegeW,
  output csrPkg::xlenT     csrReadValW,    // Registered read value
  output logic             illegalAccess,
  output csrPkg::xlenT     trapVector,
  output csrPkg::xlenT     epc,
  output csrPkg::statusT   status,
  output csrPkg::xlenT     mie,
  output csrPkg::xlenT     mip
);

  logic         accessLive;     // Counts this cycle
  logic         regWrite;
  logic         instrRetired;
  logic         regsHit, cntHit, readOnlyWrite;
  csrPkg::xlenT regsRdVal, cntRdVal, readVal;
  csrPkg::xlenT writeVal, mipWritable, mtvec, mepc;
  csrPkg::xlenT nextEpc, nextCause, nextTval;

  // Request only counts when not stalled or flushed
  assign accessLive   = csrReq.valid & ~stallW & ~flushW;
  assign regWrite     = accessLive & csrReq.write & (privilegeW == csrPkg::mMode);
  assign instrRetired = accessLive;

  assign readVal = regsRdVal | cntRdVal;   // Non-owners drive 0

  csrWriteValue uWriteValue (.req(csrReq), .rdVal(readVal), .mipWritable, .writeVal);

  csrTrapLogic uTrapLogic (.trapReq, .writeVal, .mtvec, .mepc, .nextEpc, .nextCause,
    .nextTval, .trapVector, .epc);

  csrMachineRegs uMachineRegs (.clk, .rstN, .regWrite, .adr(csrReq.adr), .writeVal,
    .trapReq, .privilegeW, .irq, .nextEpc, .nextCause, .nextTval, .rdVal(regsRdVal),
    .hit(regsHit), .readOnlyWrite, .mipWritable, .mtvec, .mepc, .status, .mie, .mip);

  csrCounters uCounters (.clk, .rstN, .regWrite, .instrRetired, .adr(csrReq.adr),
    .writeVal, .rdVal(cntRdVal), .hit(cntHit));

  // All kept CSRs are machine level, so any user read is illegal
  assign illegalAccess = (csrReq.read & (~(regsHit | cntHit) | privilegeW == csrPkg::uMode))
                         | readOnlyWrite;

  //////////////////////////////
  // Writeback register
  //////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      csrReadValW <= '0;
    end else if (flushW) begin
      csrReadValW <= '0;       // Flush wins over stall
    end else if (!stallW) begin
      csrReadValW <= readVal;
    end
  end

endmodule

//--- source/csrCounters.sv
//////////////////////////////
// Machine counters mcycle and minstret
// 64 bits each, halves writable, gated by mcountinhibit
//////////////////////////////

`include "csrUnit_cfg.svh"

module csrCounters (
  input  logic           clk,
  input  logic           rstN,
  input  logic           regWrite,
  input  logic           instrRetired,   // One per qualified request
  input  csrPkg::csrAdrT adr,
  input  csrPkg::xlenT   writeVal,
  output csrPkg::xlenT   rdVal,
  output logic           hit
);

  logic [63:0] mcycle;
  logic [63:0] minstret;
  logic        inhCycle;         // mcountinhibit bit 0
  logic        inhRet;           // mcountinhibit bit 2

  logic wrInhibit, wrCycLo, wrCycHi, wrRetLo, wrRetHi;

  assign wrInhibit = regWrite && adr == `CSR_ADR_MCOUNTINHIBIT;
  assign wrCycLo   = regWrite && adr == `CSR_ADR_MCYCLE;
  assign wrCycHi   = regWrite && adr == `CSR_ADR_MCYCLEH;
  assign wrRetLo   = regWrite && adr == `CSR_ADR_MINSTRET;
  assign wrRetHi   = regWrite && adr == `CSR_ADR_MINSTRETH;

  // Shared next-count rule, a half write replaces the increment
  function automatic logic [63:0] nextCount(
    input logic [63:0]  cur,
    input logic         inc,
    input logic         wrLo,
    input logic         wrHi,
    input csrPkg::xlenT val
  );
    logic [63:0] res;
    res = inc ? cur + 64'd1 : cur;
    if (wrLo) res = {cur[63:32], val};
    if (wrHi) res = {val, cur[31:0]};
    return res;
  endfunction

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      inhCycle <= 1'b0;
      inhRet   <= 1'b0;
      mcycle   <= '0;
      minstret <= '0;
    end else begin
      if (wrInhibit) begin
        inhCycle <= writeVal[0];
        inhRet   <= writeVal[2];
      end
      mcycle   <= nextCount(mcycle, ~inhCycle, wrCycLo, wrCycHi, writeVal);
      minstret <= nextCount(minstret, instrRetired & ~inhRet, wrRetLo, wrRetHi, writeVal);
    end
  end

  //////////////////////////////
  // Read port
  //////////////////////////////

  always_comb begin
    hit   = 1'b1;
    rdVal = '0;
    case (adr)
      `CSR_ADR_MCOUNTINHIBIT: rdVal = {29'b0, inhRet, 1'b0, inhCycle};  // No time bit
      `CSR_ADR_MCYCLE:        rdVal = mcycle[31:0];
      `CSR_ADR_MCYCLEH:       rdVal = mcycle[63:32];
      `CSR_ADR_MINSTRET:      rdVal = minstret[31:0];
      `CSR_ADR_MINSTRETH:     rdVal = minstret[63:32];
      default:                hit = 1'b0;
    endcase
  end

endmodule

//--- source/csrMachineRegs.sv
//////////////////////////////
// Machine CSR register block
// Holds mstatus, mtvec, mepc, mcause, mtval, mscratch, mie, msip
// Trap and mret updates come before CSR writes
//////////////////////////////

`include "csrUnit_cfg.svh"

module csrMachineRegs (
  input  logic             clk,
  input  logic             rstN,
  input  logic             regWrite,      // Qualified machine write
  input  csrPkg::csrAdrT   adr,
  input  csrPkg::xlenT     writeVal,
  input  csrPkg::trapReqT  trapReq,
  input  csrPkg::privT     privilegeW,    // Privilege at trap time
  input  csrPkg::irqT      irq,
  input  csrPkg::xlenT     nextEpc,
  input  csrPkg::xlenT     nextCause,
  input  csrPkg::xlenT     nextTval,
  output csrPkg::xlenT     rdVal,
  output logic             hit,
  output logic             readOnlyWrite,
  output csrPkg::xlenT     mipWritable,
  output csrPkg::xlenT     mtvec,
  output csrPkg::xlenT     mepc,
  output csrPkg::statusT   status,
  output csrPkg::xlenT     mie,
  output csrPkg::xlenT     mip
);

  csrPkg::xlenT mscratch;
  csrPkg::xlenT mtval;
  logic [4:0]   mcause;         // {interrupt, code}
  logic         msip;           // Software interrupt pending
  csrPkg::xlenT mstatusVal;     // Packed for reading
  csrPkg::xlenT mcauseVal;

  // Per-register write strobes
  logic wrStatus, wrTvec, wrEpc, wrCause, wrTval, wrScratch, wrIe, wrIp;

  assign wrStatus  = regWrite && adr == `CSR_ADR_MSTATUS;
  assign wrTvec    = regWrite && adr == `CSR_ADR_MTVEC;
  assign wrEpc     = regWrite && adr == `CSR_ADR_MEPC;
  assign wrCause   = regWrite && adr == `CSR_ADR_MCAUSE;
  assign wrTval    = regWrite && adr == `CSR_ADR_MTVAL;
  assign wrScratch = regWrite && adr == `CSR_ADR_MSCRATCH;
  assign wrIe      = regWrite && adr == `CSR_ADR_MIE;
  assign wrIp      = regWrite && adr == `CSR_ADR_MIP;

  assign readOnlyWrite = regWrite && adr == `CSR_ADR_MHARTID;

  //////////////////////////////
  // Register updates
  //////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      status   <= '{mie: 1'b0, mpie: 1'b0, mpp: csrPkg::mMode};
      mtvec    <= `CSR_MTVEC_RESET;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
      mscratch <= '0;
      mie      <= '0;
      msip     <= 1'b0;
    end else begin
      // mstatus: trap, then mret, then CSR write
      if (trapReq.trap) begin
        status.mpie <= status.mie;
        status.mie  <= 1'b0;
        status.mpp  <= privilegeW;
      end else if (trapReq.mret) begin
        status.mie  <= status.mpie;
        status.mpie <= 1'b1;
        status.mpp  <= csrPkg::uMode;
      end else if (wrStatus) begin
        status.mie  <= writeVal[3];
        status.mpie <= writeVal[7];
        status.mpp  <= (writeVal[12:11] == 2'b11) ? csrPkg::mMode : csrPkg::uMode;  // WARL
      end

      // Trap state, next values already muxed by the trap logic
      if (trapReq.trap || wrEpc) mepc <= nextEpc;
      if (trapReq.trap || wrCause) mcause <= nextCause[4:0];
      if (trapReq.trap || wrTval) mtval <= nextTval;

      if (wrTvec) mtvec <= {writeVal[`CSR_XLEN-1:2], 1'b0, writeVal[0]};  // Modes 0/1 only
      if (wrScratch) mscratch <= writeVal;
      if (wrIe) mie <= writeVal & `CSR_MIE_MASK;
      if (wrIp) msip <= writeVal[3];
    end
  end

  //////////////////////////////
  // Derived views
  //////////////////////////////

  assign mstatusVal = {19'b0, status.mpp, 3'b0, status.mpie, 3'b0, status.mie, 3'b0};
  assign mcauseVal  = {mcause[4], 27'b0, mcause[3:0]};  // Interrupt flag in MSB

  // External and timer lines are read-only, software bit is ORed with msip
  assign mip = {20'b0, irq.mExt, 3'b0, irq.mTimer, 3'b0, irq.mSw | msip, 3'b0};
  assign mipWritable = {28'b0, msip, 3'b0};

  //////////////////////////////
  // Read mux
  //////////////////////////////

  always_comb begin
    hit   = 1'b1;
    rdVal = '0;
    case (adr)
      `CSR_ADR_MSTATUS:  rdVal = mstatusVal;
      `CSR_ADR_MTVEC:    rdVal = mtvec;
      `CSR_ADR_MEPC:     rdVal = mepc;
      `CSR_ADR_MCAUSE:   rdVal = mcauseVal;
      `CSR_ADR_MTVAL:    rdVal = mtval;
      `CSR_ADR_MSCRATCH: rdVal = mscratch;
      `CSR_ADR_MIE:      rdVal = mie;
      `CSR_ADR_MIP:      rdVal = mip;
      `CSR_ADR_MHARTID:  rdVal = `CSR_HART_ID;
      default:           hit = 1'b0;   // Not ours, leave bus at 0
    endcase
  end

endmodule

//--- source/csrTrapLogic.sv
//////////////////////////////
// Trap side of the CSR unit, all combinational
// Next mepc/mcause/mtval, the trap vector and the mret target
//////////////////////////////

`include "csrUnit_cfg.svh"

module csrTrapLogic (
  input  csrPkg::trapReqT trapReq,
  input  csrPkg::xlenT    writeVal,    // CSR instruction write data
  input  csrPkg::xlenT    mtvec,
  input  csrPkg::xlenT    mepc,
  output csrPkg::xlenT    nextEpc,
  output csrPkg::xlenT    nextCause,   // {interrupt, code} in the low 5 bits
  output csrPkg::xlenT    nextTval,
  output csrPkg::xlenT    trapVector,
  output csrPkg::xlenT    epc
);

  csrPkg::xlenT faultTval;    // mtval picked by cause
  csrPkg::xlenT rawEpc;       // Before word alignment
  csrPkg::xlenT tvecAligned;

  //////////////////////////////
  // mtval source
  //////////////////////////////

  always_comb begin
    if (trapReq.interrupt) begin
      faultTval = '0;
    end else begin
      case (trapReq.cause)
        `CSR_CAUSE_IACCESS, `CSR_CAUSE_BREAK, `CSR_CAUSE_IPAGE:
          faultTval = trapReq.pc;
        `CSR_CAUSE_ILLEGAL:
          faultTval = trapReq.instrOrig;
        `CSR_CAUSE_IMISALIGN, `CSR_CAUSE_LMISALIGN, `CSR_CAUSE_LACCESS,
        `CSR_CAUSE_SMISALIGN, `CSR_CAUSE_SACCESS, `CSR_CAUSE_LPAGE, `CSR_CAUSE_SPAGE:
          faultTval = trapReq.faultAdr;
        default:
          faultTval = '0;  // ecall and the rest
      endcase
    end
  end

  // Trap values win over the CSR instruction
  assign rawEpc    = trapReq.trap ? trapReq.pc : writeVal;
  assign nextEpc   = {rawEpc[`CSR_XLEN-1:2], 2'b00};      // Always word aligned
  assign nextCause = trapReq.trap ?
                     {{(`CSR_XLEN-5){1'b0}}, trapReq.interrupt, trapReq.cause} :
                     {{(`CSR_XLEN-5){1'b0}}, writeVal[`CSR_XLEN-1], writeVal[3:0]};
  assign nextTval  = trapReq.trap ? faultTval : writeVal;

  //////////////////////////////
  // Vector and return target
  //////////////////////////////

  assign tvecAligned = {mtvec[`CSR_XLEN-1:2], 2'b00};

  // Vectored mode only for interrupts, base is 64-byte aligned so no adder
  assign trapVector = (trapReq.interrupt && mtvec[1:0] == 2'b01) ?
                      {tvecAligned[`CSR_XLEN-1:6], trapReq.cause, 2'b00} : tvecAligned;

  assign epc = mepc;  // mret target

endmodule

//--- source/csrWriteValue.sv
//////////////////////////////
// Read-modify-write value for CSRRW/CSRRS/CSRRC
// Purely combinational, feeds every CSR block
//////////////////////////////

`include "csrUnit_cfg.svh"

module csrWriteValue (
  input  csrPkg::csrReqT req,          // Decoded CSR request
  input  csrPkg::xlenT   rdVal,        // Current value of addressed CSR
  input  csrPkg::xlenT   mipWritable,  // Only the software bits of mip
  output csrPkg::xlenT   writeVal
);

  csrPkg::xlenT srcVal;   // rs1 or uimm
  csrPkg::xlenT curVal;   // Value the set/clear works on

  always_comb begin
    // Zero-extended immediate or register
    srcVal = req.useImm ? csrPkg::xlenT'(req.imm) : req.srcA;

    // Set and clear on mip must leave the interrupt lines alone
    if (req.adr == `CSR_ADR_MIP) begin
      curVal = mipWritable;
    end else begin
      curVal = rdVal;
    end

    case (req.op)
      csrPkg::opRw: writeVal = srcVal;
      csrPkg::opRs: writeVal = curVal | srcVal;
      csrPkg::opRc: writeVal = curVal & ~srcVal;
      default:      writeVal = rdVal;            // No modification
    endcase
  end

endmodule

//--- source/csrPkg.sv
//////////////////////////////
// Shared types of the CSR unit
// Data words, addresses, privilege and operation enums,
// and the request and trap bundles from the core
//////////////////////////////

`include "csrUnit_cfg.svh"

package csrPkg;

  typedef logic [`CSR_XLEN-1:0]    xlenT;    // One data word
  typedef logic [`CSR_ADR_W-1:0]   csrAdrT;  // CSR number
  typedef logic [`CSR_CAUSE_W-1:0] causeT;   // Exception or interrupt code

  // Only machine and user privilege
  typedef enum logic [1:0] {
    uMode = 2'd0,
    mMode = 2'd3
  } privT;

  // Same as funct3[1:0] of the CSR instructions
  typedef enum logic [1:0] {
    opNone = 2'b00,
    opRw   = 2'b01,
    opRs   = 2'b10,
    opRc   = 2'b11
  } csrOpT;

  //////////////////////////////
  // Bundles from the core
  //////////////////////////////

  typedef struct packed {
    logic       valid;     // CSR instruction in this stage
    logic       read;
    logic       write;
    csrAdrT     adr;
    csrOpT      op;
    logic       useImm;    // uimm form
    logic [4:0] imm;
    xlenT       srcA;      // rs1 value
  } csrReqT;

  typedef struct packed {
    logic  trap;
    logic  interrupt;
    logic  mret;
    causeT cause;
    xlenT  pc;             // PC of the trapping instruction
    xlenT  faultAdr;       // Load/store or fetch address
    xlenT  instrOrig;      // Raw instruction bits
  } trapReqT;

  typedef struct packed {
    logic mExt;
    logic mTimer;
    logic mSw;
  } irqT;

  typedef struct packed {
    logic mie;
    logic mpie;
    privT mpp;
  } statusT;

endpackage

//--- include/csrUnit_cfg.svh
//////////////////////////////
// Build constants for the machine CSR unit
// Addresses, widths, reset values and the trap cause codes
// Include wherever a constant is needed
//////////////////////////////

`ifndef CSR_UNIT_CFG_SVH
`define CSR_UNIT_CFG_SVH

`define CSR_XLEN              32
`define CSR_ADR_W             12
`define CSR_CAUSE_W           4

// Machine CSR addresses
`define CSR_ADR_MSTATUS       12'h300
`define CSR_ADR_MIE           12'h304
`define CSR_ADR_MTVEC         12'h305
`define CSR_ADR_MCOUNTINHIBIT 12'h320
`define CSR_ADR_MSCRATCH      12'h340
`define CSR_ADR_MEPC          12'h341
`define CSR_ADR_MCAUSE        12'h342
`define CSR_ADR_MTVAL         12'h343
`define CSR_ADR_MIP           12'h344
`define CSR_ADR_MCYCLE        12'hB00
`define CSR_ADR_MINSTRET      12'hB02
`define CSR_ADR_MCYCLEH       12'hB80
`define CSR_ADR_MINSTRETH     12'hB82
`define CSR_ADR_MHARTID       12'hF14

`define CSR_HART_ID           32'h0000_0000
`define CSR_MTVEC_RESET       32'h0000_0100  // Direct mode
`define CSR_MIE_MASK          32'h0000_0888  // MEIE, MTIE, MSIE

// Exception codes that pick the mtval source
`define CSR_CAUSE_IMISALIGN   4'd0
`define CSR_CAUSE_IACCESS     4'd1
`define CSR_CAUSE_ILLEGAL     4'd2
`define CSR_CAUSE_BREAK       4'd3
`define CSR_CAUSE_LMISALIGN   4'd4
`define CSR_CAUSE_LACCESS     4'd5
`define CSR_CAUSE_SMISALIGN   4'd6
`define CSR_CAUSE_SACCESS     4'd7
`define CSR_CAUSE_IPAGE       4'd12
`define CSR_CAUSE_LPAGE       4'd13
`define CSR_CAUSE_SPAGE       4'd15

`endif
